// File: common/stopwatch_pkg.sv
// stopwatch shared definitions: digit sizes, time limits, bcd increment and segment decode.
package stopwatch_pkg;

    parameter int DIGIT_W    = 4;  // one bcd digit.
    parameter int NUM_DIGITS = 6;  // hh mm ss.
    parameter int SEG_W      = 7;  // segments a to g.
    parameter int TIME_W     = NUM_DIGITS * DIGIT_W;

    // per-digit limits of the time word, also the last count before wrap.
    parameter logic [TIME_W-1:0] TIME_MAX = 24'h99_59_59;

    // time word one second later, carries ripple from the seconds digit up.
    function automatic logic [TIME_W-1:0] bcd_next(input logic [TIME_W-1:0] t);
        logic [TIME_W-1:0] n;
        logic              carry;
        int                i;
        n     = t;
        carry = 1'b1;
        for (i = 0; i < NUM_DIGITS; i++) begin
            if (carry) begin
                if (t[i*DIGIT_W +: DIGIT_W] >= TIME_MAX[i*DIGIT_W +: DIGIT_W]) begin
                    n[i*DIGIT_W +: DIGIT_W] = '0;  // wrap, carry stays set.
                end else begin
                    n[i*DIGIT_W +: DIGIT_W] = t[i*DIGIT_W +: DIGIT_W] + 1'b1;
                    carry = 1'b0;
                end
            end
        end
        return n;
    endfunction

    // active-high segments, bit order gfedcba.
    function automatic logic [SEG_W-1:0] bcd_to_seg(input logic [DIGIT_W-1:0] d);
        case (d)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            default: return 7'h00;  // not bcd, blank.
        endcase
    endfunction

endpackage

// File: rtl/tick_prescaler.sv
// one-second prescaler: free-running divider giving a single-cycle tick.
`timescale 1ns/100ps

module tick_prescaler #(
    parameter int CLK_PER_TICK = 50_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CNT_W = (CLK_PER_TICK > 1) ? $clog2(CLK_PER_TICK) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLK_PER_TICK - 1);

    logic [CNT_W-1:0] count;

    // counts down to zero, then reloads.
    // tick is registered, so the first one shows CLK_PER_TICK cycles after release.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= RELOAD;
            tick  <= 1'b0;
        end else begin
            if (count == '0) begin
                count <= RELOAD;
                tick  <= 1'b1;
            end else begin
                count <= count - 1'b1;
                tick  <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/button_conditioner.sv
// start button conditioner: synchronizer, debounce filter and press pulse.
`timescale 1ns/100ps

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  logic clk,
    input  logic rst,
    input  logic start_n,      // raw button, active low.
    output logic start_pulse
);

    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    logic             sync_a;
    logic             sync_b;
    logic             stable;  // debounced level.
    logic [CNT_W-1:0] count;

    // two-flop synchronizer, idles high like the button.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync_a <= 1'b1;
            sync_b <= 1'b1;
        end else begin
            sync_a <= start_n;
            sync_b <= sync_a;
        end
    end

    // the new level must differ from the stable one for DEBOUNCE_CYCLES cycles in a row.
    // any bounce back restarts the count.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stable      <= 1'b1;
            count       <= '0;
            start_pulse <= 1'b0;
        end else begin
            start_pulse <= 1'b0;
            if (sync_b != stable) begin
                if (count == LAST) begin
                    stable      <= sync_b;
                    count       <= '0;
                    start_pulse <= stable & ~sync_b;  // high to low only.
                end else begin
                    count <= count + 1'b1;
                end
            end else begin
                count <= '0;
            end
        end
    end

endmodule

// File: rtl/bcd_time_counter.sv
// hh:mm:ss bcd time counter with run state, stopping on wrap from 99:59:59.
`timescale 1ns/100ps

module bcd_time_counter import stopwatch_pkg::*; (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            tick,         // one-second strobe.
    input  logic                            start_pulse,  // debounced press.
    output logic [NUM_DIGITS*DIGIT_W-1:0]   time_bcd,
    output logic                            running
);

    logic [NUM_DIGITS*DIGIT_W-1:0] next_time;
    logic                          at_max;
    logic                          advance;

    assign next_time = bcd_next(time_bcd);
    assign at_max    = (time_bcd == TIME_MAX);  // last second before wrap.
    assign advance   = tick & running;

    // run state.
    // a press while running changes nothing, the wrap tick stops the watch.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            running <= 1'b0;
        end else begin
            if (advance && at_max) begin
                running <= 1'b0;
            end else if (start_pulse) begin
                running <= 1'b1;
            end
        end
    end

    // time word.
    // steps once per tick while running, otherwise parked at zero.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            time_bcd <= '0;
        end else begin
            if (!running) begin
                time_bcd <= '0;
            end else if (tick) begin
                time_bcd <= next_time;  // 99:59:59 rolls to zero here.
            end
        end
    end

endmodule

// File: rtl/seg_display_scan.sv
// seven-segment scanner: shows one digit of the time word at a time.
`timescale 1ns/100ps

module seg_display_scan import stopwatch_pkg::*; #(
    parameter int SCAN_CYCLES = 50_000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [NUM_DIGITS*DIGIT_W-1:0]   time_bcd,
    output logic [SEG_W-1:0]                seg,
    output logic [NUM_DIGITS-1:0]           digit_sel  // one-hot, active high.
);

    localparam int DWELL_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
    localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(SCAN_CYCLES - 1);
    localparam int IDX_W = $clog2(NUM_DIGITS);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(NUM_DIGITS - 1);

    logic [DWELL_W-1:0]    dwell;
    logic [IDX_W-1:0]      idx;
    logic [DIGIT_W-1:0]    cur_digit;
    logic [NUM_DIGITS-1:0] cur_sel;

    assign cur_digit = time_bcd[idx*DIGIT_W +: DIGIT_W];
    assign cur_sel   = NUM_DIGITS'(1) << idx;

    // dwell counter and digit index, 0 up to 5 then back to 0.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dwell <= '0;
            idx   <= '0;
        end else begin
            if (dwell == DWELL_LAST) begin
                dwell <= '0;
                if (idx == IDX_LAST) begin
                    idx <= '0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end else begin
                dwell <= dwell + 1'b1;
            end
        end
    end

    // select and segments share one register stage,
    // so a digit change never shows the previous digit's pattern.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digit_sel <= NUM_DIGITS'(1);
            seg       <= bcd_to_seg('0);  // digit 0 showing zero.
        end else begin
            digit_sel <= cur_sel;
            seg       <= bcd_to_seg(cur_digit);
        end
    end

endmodule

// File: rtl/stopwatch_top.sv
// stopwatch top level: prescaler, button conditioner, time counter and display scanner.
`timescale 1ns/100ps

module stopwatch_top import stopwatch_pkg::*; #(
    parameter int CLK_PER_TICK    = 50_000_000,
    parameter int DEBOUNCE_CYCLES = 1_000_000,
    parameter int SCAN_CYCLES     = 50_000
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_n,
    output logic [NUM_DIGITS*DIGIT_W-1:0]   time_bcd,
    output logic                            running,
    output logic [SEG_W-1:0]                seg,
    output logic [NUM_DIGITS-1:0]           digit_sel
);

    logic tick;         // one-second strobe.
    logic start_pulse;  // debounced press.

    tick_prescaler #(
        .CLK_PER_TICK (CLK_PER_TICK)
    ) tick_prescaler_i (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    button_conditioner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) button_conditioner_i (
        .clk         (clk),
        .rst         (rst),
        .start_n     (start_n),
        .start_pulse (start_pulse)
    );

    bcd_time_counter bcd_time_counter_i (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .start_pulse (start_pulse),
        .time_bcd    (time_bcd),
        .running     (running)
    );

    seg_display_scan #(
        .SCAN_CYCLES (SCAN_CYCLES)
    ) seg_display_scan_i (
        .clk       (clk),
        .rst       (rst),
        .time_bcd  (time_bcd),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

endmodule

// File: sim/stopwatch_props.sv
// stopwatch checker: concurrent assertions on reset, start, counting, wrap and display.
`timescale 1ns/100ps

module stopwatch_props import stopwatch_pkg::*; #(
    parameter int CLK_PER_TICK    = 4,
    parameter int DEBOUNCE_CYCLES = 8,
    parameter int SCAN_CYCLES     = 3
) (
    input logic                          clk,
    input logic                          rst,
    input logic                          start_n,
    input logic [NUM_DIGITS*DIGIT_W-1:0] time_bcd,
    input logic                          running,
    input logic [SEG_W-1:0]              seg,
    input logic [NUM_DIGITS-1:0]         digit_sel
);

    localparam int TW          = NUM_DIGITS * DIGIT_W;
    localparam int ALL_SECONDS = 100 * 3600;             // 00:00:00 up to 99:59:59.
    localparam int SCAN_LIMIT  = NUM_DIGITS * SCAN_CYCLES;
    localparam logic [TW-1:0] LAST_TIME = 24'h99_59_59;

    int failures = 0;  // raised by every failing assertion.

    // time word as a plain count of seconds.
    function automatic int to_seconds(input logic [TW-1:0] t);
        int d [NUM_DIGITS];
        for (int i = 0; i < NUM_DIGITS; i++) begin
            d[i] = int'(t[i*DIGIT_W +: DIGIT_W]);
        end
        return d[0] + 10 * d[1] + 60 * (d[2] + 10 * d[3]) + 3600 * (d[4] + 10 * d[5]);
    endfunction

    function automatic logic [TW-1:0] from_seconds(input int s);
        int hh;
        int mm;
        int ss;
        hh = s / 3600;
        mm = (s / 60) % 60;
        ss = s % 60;
        return {DIGIT_W'(hh / 10), DIGIT_W'(hh % 10), DIGIT_W'(mm / 10),
                DIGIT_W'(mm % 10), DIGIT_W'(ss / 10), DIGIT_W'(ss % 10)};
    endfunction

    function automatic logic [TW-1:0] expected_next(input logic [TW-1:0] t);
        return from_seconds((to_seconds(t) + 1) % ALL_SECONDS);
    endfunction

    // tens of seconds and tens of minutes stop at 5, all others at 9.
    function automatic logic digits_in_range(input logic [TW-1:0] t);
        int limit;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            limit = (i == 1 || i == 3) ? 5 : 9;
            if (int'(t[i*DIGIT_W +: DIGIT_W]) > limit) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // segments gfedcba, active high.
    function automatic logic [SEG_W-1:0] segment_pattern(input logic [DIGIT_W-1:0] d);
        case (d)
            4'd0:    return 7'b011_1111;
            4'd1:    return 7'b000_0110;
            4'd2:    return 7'b101_1011;
            4'd3:    return 7'b100_1111;
            4'd4:    return 7'b110_0110;
            4'd5:    return 7'b110_1101;
            4'd6:    return 7'b111_1101;
            4'd7:    return 7'b000_0111;
            4'd8:    return 7'b111_1111;
            4'd9:    return 7'b110_1111;
            default: return 7'b000_0000;
        endcase
    endfunction

    function automatic logic [DIGIT_W-1:0] shown_digit(input logic [TW-1:0] t,
                                                       input logic [NUM_DIGITS-1:0] sel);
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (sel[i]) begin
                return t[i*DIGIT_W +: DIGIT_W];
            end
        end
        return '0;
    endfunction

    logic [TW-1:0] prev_time;
    int            change_gap;             // cycles since the last time change.
    int            low_len;                // consecutive low samples of the button.
    logic          press_ok;               // a long enough press since the watch stopped.
    int            since_sel [NUM_DIGITS];
    logic          scan_ok;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prev_time  <= '0;
            change_gap <= CLK_PER_TICK;
            low_len    <= 0;
            press_ok   <= 1'b0;
            for (int i = 0; i < NUM_DIGITS; i++) begin
                since_sel[i] <= 0;
            end
        end else begin
            prev_time <= time_bcd;
            if (time_bcd != prev_time) begin
                change_gap <= 1;
            end else if (change_gap < CLK_PER_TICK) begin
                change_gap <= change_gap + 1;
            end
            if (start_n) begin
                low_len <= 0;
            end else if (low_len < DEBOUNCE_CYCLES) begin
                low_len <= low_len + 1;
            end
            press_ok <= running ? 1'b0 : (press_ok | (low_len >= DEBOUNCE_CYCLES));
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (digit_sel[i]) begin
                    since_sel[i] <= 0;
                end else if (since_sel[i] < SCAN_LIMIT) begin
                    since_sel[i] <= since_sel[i] + 1;
                end
            end
        end
    end

    always_comb begin
        scan_ok = 1'b1;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (since_sel[i] >= SCAN_LIMIT) begin
                scan_ok = 1'b0;
            end
        end
    end

    reset_state: assert property (@(posedge clk)
        !rst |-> (time_bcd == '0 && !running && digit_sel == NUM_DIGITS'(1)))
        else begin
            failures = failures + 1;
            $error("FAILED reset_state: expected 000000 0 000001, actual %h %b %b",
                   $sampled(time_bcd), $sampled(running), $sampled(digit_sel));
        end

    start_needs_press: assert property (@(posedge clk) disable iff (!rst)
        $rose(running) |-> press_ok)
        else begin
            failures = failures + 1;
            $error("FAILED start_needs_press: expected press 1, actual %b", $sampled(press_ok));
        end

    stopped_at_zero: assert property (@(posedge clk) disable iff (!rst)
        !running |-> time_bcd == '0)
        else begin
            failures = failures + 1;
            $error("FAILED stopped_at_zero: expected 000000, actual %h", $sampled(time_bcd));
        end

    count_step: assert property (@(posedge clk) disable iff (!rst)
        (time_bcd != prev_time) |-> time_bcd == expected_next(prev_time))
        else begin
            failures = failures + 1;
            $error("FAILED count_step: expected %h, actual %h",
                   expected_next($sampled(prev_time)), $sampled(time_bcd));
        end

    change_spacing: assert property (@(posedge clk) disable iff (!rst)
        (time_bcd != prev_time) |-> change_gap >= CLK_PER_TICK)
        else begin
            failures = failures + 1;
            $error("FAILED change_spacing: expected gap >= %0d, actual %0d",
                   CLK_PER_TICK, $sampled(change_gap));
        end

    digit_range: assert property (@(posedge clk) digits_in_range(time_bcd))
        else begin
            failures = failures + 1;
            $error("FAILED digit_range: expected valid hh:mm:ss, actual %h", $sampled(time_bcd));
        end

    wrap_stop: assert property (@(posedge clk) disable iff (!rst)
        (prev_time == LAST_TIME && time_bcd == '0) |-> !running)
        else begin
            failures = failures + 1;
            $error("FAILED wrap_stop: expected running 0, actual %b", $sampled(running));
        end

    stop_only_on_wrap: assert property (@(posedge clk) disable iff (!rst)
        $fell(running) |-> (prev_time == LAST_TIME && time_bcd == '0))
        else begin
            failures = failures + 1;
            $error("FAILED stop_only_on_wrap: expected %h to 000000, actual %h to %h",
                   LAST_TIME, $sampled(prev_time), $sampled(time_bcd));
        end

    sel_onehot: assert property (@(posedge clk) $onehot(digit_sel))
        else begin
            failures = failures + 1;
            $error("FAILED sel_onehot: expected one-hot, actual %b", $sampled(digit_sel));
        end

    seg_matches: assert property (@(posedge clk) disable iff (!rst)
        seg == segment_pattern(shown_digit(prev_time, digit_sel)))
        else begin
            failures = failures + 1;
            $error("FAILED seg_matches: expected %b, actual %b",
                   segment_pattern(shown_digit($sampled(prev_time), $sampled(digit_sel))),
                   $sampled(seg));
        end

    scan_visits: assert property (@(posedge clk) disable iff (!rst) scan_ok)
        else begin
            failures = failures + 1;
            $error("FAILED scan_visits: expected every digit within %0d cycles, actual %b",
                   SCAN_LIMIT, $sampled(scan_ok));
        end

endmodule

// File: sim/stopwatch_tb.sv
// stopwatch testbench that drives reset and the start button while the bound checker judges the DUT.
`timescale 1ns/100ps

module stopwatch_tb import stopwatch_pkg::*;;

    localparam int CLK_PER_TICK     = 4;
    localparam int DEBOUNCE_CYCLES  = 8;
    localparam int SCAN_CYCLES      = 3;
    localparam int FULL_RUN_SECONDS = 360_000;
    localparam int TIMEOUT_CYCLES   = FULL_RUN_SECONDS * CLK_PER_TICK + 20_000;
    localparam int BOUNCE_COUNT     = 20;
    localparam int PRESS_CYCLES     = DEBOUNCE_CYCLES + 4;  // comfortably past the filter.

    logic                          clk;
    logic                          rst;
    logic                          start_n;
    logic [NUM_DIGITS*DIGIT_W-1:0] time_bcd;
    logic                          running;
    logic [SEG_W-1:0]              seg;
    logic [NUM_DIGITS-1:0]         digit_sel;

    int     cycle_count = 0;
    integer seed        = 32'h1237_a984;

    stopwatch_top #(
        .CLK_PER_TICK    (CLK_PER_TICK),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .SCAN_CYCLES     (SCAN_CYCLES)
    ) stopwatch_top_i (
        .clk       (clk),
        .rst       (rst),
        .start_n   (start_n),
        .time_bcd  (time_bcd),
        .running   (running),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

    bind stopwatch_top stopwatch_props #(
        .CLK_PER_TICK    (CLK_PER_TICK),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .SCAN_CYCLES     (SCAN_CYCLES)
    ) stopwatch_props_i (
        .clk       (clk),
        .rst       (rst),
        .start_n   (start_n),
        .time_bcd  (time_bcd),
        .running   (running),
        .seg       (seg),
        .digit_sel (digit_sel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : timeout_guard
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation timed out after %0d cycles", TIMEOUT_CYCLES);
    end

    // first assertion failure ends the run.
    initial begin : assertion_watch
        wait (stopwatch_top_i.stopwatch_props_i.failures != 0);
        $display("TEST RESULT: FAIL");
        $fatal(1, "an assertion on the stopwatch failed");
    end

    task automatic apply_reset();
        rst <= 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic press_button(input int low_cycles);
        start_n <= 1'b0;
        repeat (low_cycles) @(posedge clk);
        start_n <= 1'b1;
        @(posedge clk);
    endtask

    // contact bounce with every low stretch shorter than the filter.
    task automatic bounce_button(input int count);
        int low_len;
        int high_len;
        for (int n = 0; n < count; n++) begin
            low_len  = 1 + int'($unsigned($random(seed)) % 32'd5);
            high_len = 1 + int'($unsigned($random(seed)) % 32'd5);
            start_n <= 1'b0;
            repeat (low_len) @(posedge clk);
            start_n <= 1'b1;
            repeat (high_len) @(posedge clk);
        end
    endtask

    // waits on the falling edge where running is settled.
    task automatic wait_running(input logic level);
        @(negedge clk);
        while (running !== level) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin : stimulus
        rst     = 1'b1;
        start_n = 1'b1;
        apply_reset();
        idle(20);

        bounce_button(BOUNCE_COUNT);
        idle(DEBOUNCE_CYCLES + 10);   // watch must still be stopped.

        press_button(PRESS_CYCLES);
        wait_running(1'b1);
        idle(5 * CLK_PER_TICK);
        press_button(PRESS_CYCLES);   // second press while counting.

        wait_running(1'b0);           // full run up to the wrap.
        idle(10 * CLK_PER_TICK);      // time parked at zero.

        press_button(PRESS_CYCLES);
        wait_running(1'b1);
        idle(12 * CLK_PER_TICK);
        apply_reset();                // reset in the middle of a run.
        idle(10);
        press_button(PRESS_CYCLES);
        wait_running(1'b1);
        idle(8 * CLK_PER_TICK);

        if (stopwatch_top_i.stopwatch_props_i.failures == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "an assertion on the stopwatch failed");
        end
    end

endmodule

// File: compile.f
common/stopwatch_pkg.sv
rtl/tick_prescaler.sv
rtl/button_conditioner.sv
rtl/bcd_time_counter.sv
rtl/seg_display_scan.sv
rtl/stopwatch_top.sv
sim/stopwatch_props.sv
sim/stopwatch_tb.sv

// File: Makefile
# Verilator build and run of the stopwatch testbench.

VERILATOR ?= verilator
TOP       ?= stopwatch_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/100ps
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass message shows in the simulator output.
run: compile
	@out="$$(./$(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
